// ==== verilog/ntt_buf_pkg.sv ====
`default_nettype none

package ntt_buf_pkg;

  localparam int WORD_W      = 64;  // Block memory word
  localparam int AXIS_W      = 32;  // Stream beat
  localparam int NUM_LANES   = 8;
  localparam int LANE_W      = 8;
  localparam int COEF_W      = 16;  // NTT coefficient
  localparam int AXIL_ADDR_W = 12;

  localparam logic [AXIL_ADDR_W-1:0] STATUS_ADDR = 12'h000;

  // Command bits 3:2 that open a block
  localparam logic [1:0] CMD_START = 2'b01;

  // Complex sample, x arrives first on the stream
  typedef struct packed {
    logic [AXIS_W-1:0] y;
    logic [AXIS_W-1:0] x;
  } fft_word_t;

  typedef struct packed {
    logic [WORD_W-COEF_W-1:0] pad;
    logic [COEF_W-1:0]        coef;
  } ntt_word_t;

  // Same memory word seen in either format
  typedef union packed {
    fft_word_t fft;
    ntt_word_t ntt;
  } mem_word_t;

endpackage

`default_nettype wire

// ==== verilog/sram_lane.sv ====
`timescale 1ns/10ps
`default_nettype none

module sram_lane #(
  parameter int ADDR_W = 4
) (
  input  logic                           axi_clk,
  input  logic                           wr_en,
  input  logic [ADDR_W-1:0]              wr_addr,
  input  logic [ntt_buf_pkg::LANE_W-1:0] wr_byte,
  input  logic                           rd_en,
  input  logic [ADDR_W-1:0]              rd_addr,
  output logic [ntt_buf_pkg::LANE_W-1:0] rd_byte
);

  logic [ntt_buf_pkg::LANE_W-1:0] mem [2**ADDR_W];

  always_ff @(posedge axi_clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_byte;
    end
  end

  // Registered read, data valid the cycle after rd_en
  always_ff @(posedge axi_clk) begin
    if (rd_en) begin
      rd_byte <= mem[rd_addr];
    end
  end

endmodule

`default_nettype wire

// ==== verilog/xform_ctrl.sv ====
`timescale 1ns/10ps
`default_nettype none

module xform_ctrl (
  input  logic                                axi_clk,
  input  logic                                axi_reset_n,
  input  logic                                ss_tvalid,
  input  logic [3:0]                          ss_tdata,     // Command bits only
  output logic                                cmd_ready,
  output logic                                load_start,
  output logic                                unload_start,
  output logic                                fmt_ntt,
  input  logic                                load_done,
  input  logic                                unload_done,
  input  logic                                awvalid,
  input  logic [ntt_buf_pkg::AXIL_ADDR_W-1:0] awaddr,
  input  logic                                wvalid,
  input  logic [ntt_buf_pkg::AXIS_W-1:0]      wdata,
  output logic                                awready,
  output logic                                wready,
  input  logic                                arvalid,
  input  logic [ntt_buf_pkg::AXIL_ADDR_W-1:0] araddr,
  output logic                                arready,
  output logic                                rvalid,
  input  logic                                rready,
  output logic [ntt_buf_pkg::AXIS_W-1:0]      rdata
);

  localparam logic [1:0] PH_CMD    = 2'd0;
  localparam logic [1:0] PH_LOAD   = 2'd1;
  localparam logic [1:0] PH_UNLOAD = 2'd2;
  localparam logic [1:0] PH_DONE   = 2'd3;

  logic [1:0]                          phase;
  logic                                start_cmd;
  logic                                restart;
  logic [ntt_buf_pkg::AXIL_ADDR_W-1:0] rd_addr_q;

  // Bit 0 of the command is ignored, bit 1 selects NTT
  assign start_cmd = ss_tvalid && cmd_ready && (ss_tdata[3:2] == ntt_buf_pkg::CMD_START);

  // Address and data are taken together in one cycle
  assign awready = awvalid && wvalid;
  assign wready  = awvalid && wvalid;
  assign restart = awready && (awaddr == ntt_buf_pkg::STATUS_ADDR) && wdata[0];

  always_ff @(posedge axi_clk or negedge axi_reset_n) begin
    if (!axi_reset_n) begin
      phase        <= PH_CMD;
      cmd_ready    <= 1'b0;
      load_start   <= 1'b0;
      unload_start <= 1'b0;
      fmt_ntt      <= 1'b0;
    end else begin
      load_start   <= 1'b0;
      unload_start <= 1'b0;
      case (phase)
        PH_CMD: begin
          cmd_ready <= !start_cmd;  // Any other beat is just dropped
          if (start_cmd) begin
            phase      <= PH_LOAD;
            fmt_ntt    <= ss_tdata[1];
            load_start <= 1'b1;
          end
        end
        PH_LOAD: begin
          if (load_done) begin
            phase        <= PH_UNLOAD;
            unload_start <= 1'b1;
          end
        end
        PH_UNLOAD: begin
          if (unload_done) begin
            phase <= PH_DONE;
          end
        end
        default: begin
          if (restart) begin
            phase     <= PH_CMD;
            cmd_ready <= 1'b1;
          end
        end
      endcase
    end
  end

  // One read outstanding at a time
  assign arready = !rvalid;

  always_ff @(posedge axi_clk or negedge axi_reset_n) begin
    if (!axi_reset_n) begin
      rvalid <= 1'b0;
    end else if (arvalid && arready) begin
      rvalid <= 1'b1;
    end else if (rready) begin
      rvalid <= 1'b0;
    end
  end

  always_ff @(posedge axi_clk) begin
    if (arvalid && arready) begin
      rd_addr_q <= araddr;
    end
  end

  assign rdata = (rd_addr_q == ntt_buf_pkg::STATUS_ADDR) ?
                 ntt_buf_pkg::AXIS_W'(phase == PH_DONE) : '0;

endmodule

`default_nettype wire

// ==== verilog/stream_loader.sv ====
`timescale 1ns/10ps
`default_nettype none

module stream_loader #(
  parameter int BLOCK_WORDS = 16
) (
  input  logic                           axi_clk,
  input  logic                           axi_reset_n,
  input  logic                           load_start,
  input  logic                           fmt_ntt,
  input  logic                           ss_tvalid,
  input  logic [ntt_buf_pkg::AXIS_W-1:0] ss_tdata,
  output logic                           in_ready,
  output logic                           wr_en,
  output logic [$clog2(BLOCK_WORDS)-1:0] wr_addr,
  output ntt_buf_pkg::mem_word_t         wr_data,
  output logic                           load_done
);

  localparam int ADDR_W = $clog2(BLOCK_WORDS);

  logic                           beat;
  logic                           y_phase;   // Next FFT beat completes a word
  logic                           last_word;
  logic [ADDR_W-1:0]              word_cnt;
  logic [ntt_buf_pkg::AXIS_W-1:0] x_hold;

  assign beat      = ss_tvalid && in_ready;
  assign wr_en     = beat && (fmt_ntt || y_phase);
  assign wr_addr   = word_cnt;
  assign last_word = (word_cnt == ADDR_W'(BLOCK_WORDS - 1));

  always_comb begin
    if (fmt_ntt) begin
      wr_data.ntt.pad  = '0;
      wr_data.ntt.coef = ss_tdata[ntt_buf_pkg::COEF_W-1:0];
    end else begin
      wr_data.fft.x = x_hold;
      wr_data.fft.y = ss_tdata;   // y goes straight in with the held x
    end
  end

  always_ff @(posedge axi_clk or negedge axi_reset_n) begin
    if (!axi_reset_n) begin
      in_ready  <= 1'b0;
      y_phase   <= 1'b0;
      word_cnt  <= '0;
      load_done <= 1'b0;
    end else begin
      load_done <= 1'b0;
      if (load_start) begin
        in_ready <= 1'b1;
        y_phase  <= 1'b0;
        word_cnt <= '0;
      end else begin
        if (beat && !fmt_ntt) begin
          y_phase <= !y_phase;
        end
        if (wr_en) begin
          word_cnt <= word_cnt + 1'b1;
          if (last_word) begin
            in_ready  <= 1'b0;
            load_done <= 1'b1;
          end
        end
      end
    end
  end

  always_ff @(posedge axi_clk) begin
    if (beat && !fmt_ntt && !y_phase) begin
      x_hold <= ss_tdata;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/stream_unloader.sv ====
`timescale 1ns/10ps
`default_nettype none

module stream_unloader #(
  parameter int BLOCK_WORDS = 16
) (
  input  logic                           axi_clk,
  input  logic                           axi_reset_n,
  input  logic                           unload_start,
  input  logic                           fmt_ntt,
  output logic                           rd_en,
  output logic [$clog2(BLOCK_WORDS)-1:0] rd_addr,
  input  ntt_buf_pkg::mem_word_t         rd_word,
  output logic                           sm_tvalid,
  input  logic                           sm_tready,
  output logic [ntt_buf_pkg::AXIS_W-1:0] sm_tdata,
  output logic                           sm_tlast,
  output logic                           unload_done
);

  localparam int ADDR_W = $clog2(BLOCK_WORDS);
  localparam int BEAT_W = ADDR_W + 1;   // FFT block is twice as many beats

  logic                   rd_active;
  logic                   in_flight;
  ntt_buf_pkg::mem_word_t word_buf [2];
  ntt_buf_pkg::mem_word_t head;
  logic                   wr_ptr;
  logic                   rd_ptr;
  logic [1:0]             count;
  logic [1:0]             occupancy;
  logic                   hi_half;       // FFT y beat is next
  logic [BEAT_W-1:0]      beat_cnt;
  logic [BEAT_W-1:0]      last_beat;
  logic                   beat;
  logic                   word_pop;

  assign head      = word_buf[rd_ptr];
  assign sm_tvalid = (count != 2'd0);
  assign beat      = sm_tvalid && sm_tready;
  assign word_pop  = beat && (fmt_ntt || hi_half);

  // Buffered words plus the one on its way from the lanes
  assign occupancy = count + {1'b0, in_flight};
  assign rd_en     = rd_active && ((occupancy != 2'd2) || word_pop);

  assign last_beat = fmt_ntt ? BEAT_W'(BLOCK_WORDS - 1) : BEAT_W'(2 * BLOCK_WORDS - 1);
  assign sm_tlast    = sm_tvalid && (beat_cnt == last_beat);
  assign unload_done = beat && sm_tlast;

  always_comb begin
    if (fmt_ntt) begin
      sm_tdata = {{(ntt_buf_pkg::AXIS_W - ntt_buf_pkg::COEF_W){1'b0}}, head.ntt.coef};
    end else begin
      sm_tdata = hi_half ? head.fft.y : head.fft.x;
    end
  end

  always_ff @(posedge axi_clk or negedge axi_reset_n) begin
    if (!axi_reset_n) begin
      rd_active <= 1'b0;
      in_flight <= 1'b0;
      rd_addr   <= '0;
      wr_ptr    <= 1'b0;
      rd_ptr    <= 1'b0;
      count     <= 2'd0;
      hi_half   <= 1'b0;
      beat_cnt  <= '0;
    end else begin
      in_flight <= rd_en;
      if (unload_start) begin
        rd_active <= 1'b1;
        rd_addr   <= '0;
        hi_half   <= 1'b0;
        beat_cnt  <= '0;
      end else begin
        if (rd_en) begin
          rd_addr <= rd_addr + 1'b1;
          if (rd_addr == ADDR_W'(BLOCK_WORDS - 1)) begin
            rd_active <= 1'b0;
          end
        end
        if (beat) begin
          beat_cnt <= beat_cnt + 1'b1;
          if (!fmt_ntt) begin
            hi_half <= !hi_half;
          end
        end
      end
      if (in_flight) begin
        wr_ptr <= !wr_ptr;
      end
      if (word_pop) begin
        rd_ptr <= !rd_ptr;
      end
      count <= count + {1'b0, in_flight} - {1'b0, word_pop};
    end
  end

  always_ff @(posedge axi_clk) begin
    if (in_flight) begin
      word_buf[wr_ptr] <= rd_word;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/ntt_buf_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module ntt_buf_top #(
  parameter int BLOCK_WORDS = 16
) (
  input  logic                                axi_clk,
  input  logic                                axi_reset_n,
  input  logic                                ss_tvalid,
  output logic                                ss_tready,
  input  logic [ntt_buf_pkg::AXIS_W-1:0]      ss_tdata,
  input  logic                                ss_tlast,  // Block length comes from the command
  output logic                                sm_tvalid,
  input  logic                                sm_tready,
  output logic [ntt_buf_pkg::AXIS_W-1:0]      sm_tdata,
  output logic                                sm_tlast,
  input  logic                                awvalid,
  input  logic [ntt_buf_pkg::AXIL_ADDR_W-1:0] awaddr,
  output logic                                awready,
  input  logic                                wvalid,
  input  logic [ntt_buf_pkg::AXIS_W-1:0]      wdata,
  output logic                                wready,
  input  logic                                arvalid,
  input  logic [ntt_buf_pkg::AXIL_ADDR_W-1:0] araddr,
  output logic                                arready,
  output logic                                rvalid,
  input  logic                                rready,
  output logic [ntt_buf_pkg::AXIS_W-1:0]      rdata
);

  localparam int ADDR_W = $clog2(BLOCK_WORDS);
  localparam int LW     = ntt_buf_pkg::LANE_W;

  wire                             cmd_ready;
  wire                             in_ready;
  wire                             load_start;
  wire                             load_done;
  wire                             unload_start;
  wire                             unload_done;
  wire                             fmt_ntt;
  wire                             wr_en;
  wire [ADDR_W-1:0]                wr_addr;
  wire [ntt_buf_pkg::WORD_W-1:0]   wr_bus;
  wire                             rd_en;
  wire [ADDR_W-1:0]                rd_addr;
  wire [ntt_buf_pkg::WORD_W-1:0]   rd_bus;

  // Controller takes commands, loader takes data
  assign ss_tready = cmd_ready | in_ready;

  xform_ctrl xform_ctrl_inst (
    .axi_clk      (axi_clk),
    .axi_reset_n  (axi_reset_n),
    .ss_tvalid    (ss_tvalid),
    .ss_tdata     (ss_tdata[3:0]),
    .cmd_ready    (cmd_ready),
    .load_start   (load_start),
    .unload_start (unload_start),
    .fmt_ntt      (fmt_ntt),
    .load_done    (load_done),
    .unload_done  (unload_done),
    .awvalid      (awvalid),
    .awaddr       (awaddr),
    .wvalid       (wvalid),
    .wdata        (wdata),
    .awready      (awready),
    .wready       (wready),
    .arvalid      (arvalid),
    .araddr       (araddr),
    .arready      (arready),
    .rvalid       (rvalid),
    .rready       (rready),
    .rdata        (rdata)
  );

  stream_loader #(.BLOCK_WORDS(BLOCK_WORDS)) stream_loader_inst (
    .axi_clk     (axi_clk),
    .axi_reset_n (axi_reset_n),
    .load_start  (load_start),
    .fmt_ntt     (fmt_ntt),
    .ss_tvalid   (ss_tvalid),
    .ss_tdata    (ss_tdata),
    .in_ready    (in_ready),
    .wr_en       (wr_en),
    .wr_addr     (wr_addr),
    .wr_data     (wr_bus),
    .load_done   (load_done)
  );

  for (genvar i = 0; i < ntt_buf_pkg::NUM_LANES; i++) begin : g_lane
    sram_lane #(.ADDR_W(ADDR_W)) sram_lane_inst (
      .axi_clk (axi_clk),
      .wr_en   (wr_en),
      .wr_addr (wr_addr),
      .wr_byte (wr_bus[i*LW +: LW]),
      .rd_en   (rd_en),
      .rd_addr (rd_addr),
      .rd_byte (rd_bus[i*LW +: LW])
    );
  end

  stream_unloader #(.BLOCK_WORDS(BLOCK_WORDS)) stream_unloader_inst (
    .axi_clk      (axi_clk),
    .axi_reset_n  (axi_reset_n),
    .unload_start (unload_start),
    .fmt_ntt      (fmt_ntt),
    .rd_en        (rd_en),
    .rd_addr      (rd_addr),
    .rd_word      (rd_bus),
    .sm_tvalid    (sm_tvalid),
    .sm_tready    (sm_tready),
    .sm_tdata     (sm_tdata),
    .sm_tlast     (sm_tlast),
    .unload_done  (unload_done)
  );

endmodule

`default_nettype wire

// ==== dv/ntt_buf_assert.sv ====
`timescale 1ns/10ps
`default_nettype none

module ntt_buf_assert (
  input logic                           axi_clk,
  input logic                           axi_reset_n,
  input logic                           sm_tvalid,
  input logic                           sm_tready,
  input logic [ntt_buf_pkg::AXIS_W-1:0] sm_tdata,
  input logic                           sm_tlast,
  input logic                           awvalid,
  input logic                           wvalid,
  input logic                           awready,
  input logic                           wready,
  input logic                           rvalid,
  input logic                           rready
);

  int fail_count = 0;  // Read by the testbench at the end of the run

  // Output beat frozen while the sink stalls
  a_sm_stable: assert property (@(posedge axi_clk) disable iff (!axi_reset_n)
    sm_tvalid && !sm_tready |=> sm_tvalid && $stable(sm_tdata) && $stable(sm_tlast))
    else begin
      fail_count++;
      $error("Output stream changed or dropped valid while stalled");
    end

  a_rvalid_hold: assert property (@(posedge axi_clk) disable iff (!axi_reset_n)
    rvalid && !rready |=> rvalid)
    else begin
      fail_count++;
      $error("Read data valid dropped before rready");
    end

  // Write address and data are taken in the same cycle
  a_aw_ready: assert property (@(posedge axi_clk) disable iff (!axi_reset_n)
    (awready == (awvalid && wvalid)) && (wready == (awvalid && wvalid)))
    else begin
      fail_count++;
      $error("Write ready does not follow awvalid and wvalid");
    end

endmodule

bind ntt_buf_top ntt_buf_assert ntt_buf_assert_inst (.*);

`default_nettype wire

// ==== dv/ntt_buf_checker.sv ====
`timescale 1ns/10ps
`default_nettype none

module ntt_buf_checker #(
  parameter int BLOCK_WORDS = 16
) (
  input  logic                                axi_clk,
  input  logic                                axi_reset_n,
  input  logic                                ss_tvalid,
  input  logic                                ss_tready,
  input  logic [31:0]                         ss_tdata,
  input  logic                                sm_tvalid,
  input  logic                                sm_tready,
  input  logic [31:0]                         sm_tdata,
  input  logic                                sm_tlast,
  input  logic                                awvalid,
  input  logic                                wvalid,
  input  logic [ntt_buf_pkg::AXIL_ADDR_W-1:0] awaddr,
  input  logic [31:0]                         wdata,
  output int                                  error_count,
  output int                                  beat_count
);

  localparam int M_CMD  = 0;
  localparam int M_LOAD = 1;
  localparam int M_OUT  = 2;
  localparam int M_DONE = 3;

  int          phase;
  int          in_left;      // Data beats still to arrive
  int          in_errors  = 0;
  int          out_errors = 0;
  int          out_cnt    = 0;
  logic        fmt_ntt;
  logic [31:0] exp_data;
  logic [31:0] exp_q [$];    // Expected output beats in order

  assign error_count = in_errors + out_errors;
  assign beat_count  = out_cnt;

  // NTT keeps the low 16 bits, FFT passes the beat through
  function automatic logic [31:0] expected_beat(input logic ntt, input logic [31:0] din);
    if (ntt) begin
      return {16'h0000, din[15:0]};
    end
    return din;
  endfunction

  // Mirror of the block phases
  always @(posedge axi_clk or negedge axi_reset_n) begin
    if (!axi_reset_n) begin
      phase   = M_CMD;
      in_left = 0;
      fmt_ntt = 1'b0;
      exp_q.delete();
    end else begin
      if (ss_tvalid && ss_tready) begin
        case (phase)
          M_CMD: begin
            if (ss_tdata[3:2] == ntt_buf_pkg::CMD_START) begin
              fmt_ntt = ss_tdata[1];
              in_left = fmt_ntt ? BLOCK_WORDS : 2 * BLOCK_WORDS;
              phase   = M_LOAD;
            end
          end
          M_LOAD: begin
            exp_q.push_back(expected_beat(fmt_ntt, ss_tdata));
            in_left = in_left - 1;
            if (in_left == 0) begin
              phase = M_OUT;
            end
          end
          default: begin
            in_errors = in_errors + 1;
            $display("Error at %0t: input beat accepted after the block was loaded", $time);
          end
        endcase
      end
      if (phase == M_OUT && sm_tvalid && sm_tready && sm_tlast) begin
        phase = M_DONE;
      end else if (phase == M_DONE && awvalid && wvalid &&
                   awaddr == ntt_buf_pkg::STATUS_ADDR && wdata[0]) begin
        phase = M_CMD;  // Restart
      end
    end
  end

  always @(posedge axi_clk) begin
    if (axi_reset_n && sm_tvalid && sm_tready) begin
      out_cnt = out_cnt + 1;
      if (exp_q.size() == 0) begin
        out_errors = out_errors + 1;
        $display("Error at %0t: output beat %h with no loaded data to match", $time, sm_tdata);
      end else begin
        exp_data = exp_q.pop_front();
        if (sm_tdata !== exp_data) begin
          out_errors = out_errors + 1;
          $display("MISMATCH at %0t: output beat %0d is %h, expected %h",
                   $time, out_cnt, sm_tdata, exp_data);
        end
        if (exp_q.size() == 0 && sm_tlast !== 1'b1) begin
          out_errors = out_errors + 1;
          $display("Error at %0t: final beat of the block came without tlast", $time);
        end else if (exp_q.size() != 0 && sm_tlast !== 1'b0) begin
          out_errors = out_errors + 1;
          $display("Error at %0t: tlast came with %0d beats of data missing",
                   $time, exp_q.size());
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== dv/tb_ntt_buf.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_ntt_buf;

  localparam int BLOCK_WORDS = 16;
  // Two NTT blocks, three FFT blocks, one bad command
  localparam int TOTAL_BEATS = 2 * (BLOCK_WORDS + 1) + 3 * (2 * BLOCK_WORDS + 1) + 1;
  localparam int CYCLE_LIMIT = 20 * TOTAL_BEATS + 200;

  logic        axi_clk;
  logic        axi_reset_n;
  logic        ss_tvalid;
  logic        ss_tready;
  logic [31:0] ss_tdata;
  logic        ss_tlast;
  logic        sm_tvalid;
  logic        sm_tready;
  logic [31:0] sm_tdata;
  logic        sm_tlast;
  logic        awvalid;
  logic [11:0] awaddr;
  logic        awready;
  logic        wvalid;
  logic [31:0] wdata;
  logic        wready;
  logic        arvalid;
  logic [11:0] araddr;
  logic        arready;
  logic        rvalid;
  logic        rready;
  logic [31:0] rdata;

  int          cycle_cnt;
  int          reg_errors;
  int          stream_errors;
  int          beats_checked;
  int          total_errors;
  logic [31:0] data_rng;
  logic [31:0] stall_rng;
  logic        gap_mode;
  logic        stall_mode;

  ntt_buf_top #(.BLOCK_WORDS(BLOCK_WORDS)) ntt_buf_top_inst (.*);

  ntt_buf_checker #(.BLOCK_WORDS(BLOCK_WORDS)) ntt_buf_checker_inst (
    .axi_clk     (axi_clk),
    .axi_reset_n (axi_reset_n),
    .ss_tvalid   (ss_tvalid),
    .ss_tready   (ss_tready),
    .ss_tdata    (ss_tdata),
    .sm_tvalid   (sm_tvalid),
    .sm_tready   (sm_tready),
    .sm_tdata    (sm_tdata),
    .sm_tlast    (sm_tlast),
    .awvalid     (awvalid),
    .wvalid      (wvalid),
    .awaddr      (awaddr),
    .wdata       (wdata),
    .error_count (stream_errors),
    .beat_count  (beats_checked)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    return x;
  endfunction

  initial axi_clk = 1'b0;
  always #50 axi_clk = ~axi_clk;

  // Sink ready about three cycles in four when stalling
  always @(posedge axi_clk) begin
    if (stall_mode) begin
      stall_rng = xorshift32(stall_rng);
      sm_tready <= (stall_rng[1:0] != 2'b00);
    end else begin
      sm_tready <= 1'b1;
    end
  end

  always @(posedge axi_clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Errors found");
      $finish;
    end
  end

  task automatic idle_gap();
    if (gap_mode) begin
      data_rng = xorshift32(data_rng);
      if (data_rng[1:0] == 2'b00) begin
        ss_tvalid <= 1'b0;
        repeat (1 + data_rng[2]) @(posedge axi_clk);
      end
    end
  endtask

  task automatic send_beat(input logic [31:0] data, input logic last);
    idle_gap();
    ss_tvalid <= 1'b1;
    ss_tdata  <= data;
    ss_tlast  <= last;
    do begin
      @(posedge axi_clk);
    end while (!ss_tready);
    ss_tvalid <= 1'b0;
    ss_tlast  <= 1'b0;
  endtask

  task automatic read_status(input logic [31:0] expected);
    arvalid <= 1'b1;
    araddr  <= ntt_buf_pkg::STATUS_ADDR;
    do begin
      @(posedge axi_clk);
    end while (!arready);
    arvalid <= 1'b0;
    do begin
      @(posedge axi_clk);
    end while (!rvalid);
    rready <= 1'b1;   // Slow master, rvalid has to wait one cycle
    @(posedge axi_clk);
    rready <= 1'b0;
    if (rdata !== expected) begin
      reg_errors++;
      $display("MISMATCH at %0t: status read %h, expected %h", $time, rdata, expected);
    end
  endtask

  task automatic write_status(input logic [31:0] value);
    awvalid <= 1'b1;
    wvalid  <= 1'b1;
    awaddr  <= ntt_buf_pkg::STATUS_ADDR;
    wdata   <= value;
    do begin
      @(posedge axi_clk);
    end while (!awready);
    awvalid <= 1'b0;
    wvalid  <= 1'b0;
  endtask

  task automatic run_block(input logic ntt, input logic bad_cmd);
    int n;
    if (bad_cmd) begin
      send_beat(32'h0000_000a, 1'b0);  // Bits 3:2 are 10
    end
    send_beat({28'h0, ntt_buf_pkg::CMD_START, ntt, 1'b1}, 1'b0);  // Bit 0 has no effect
    n = ntt ? BLOCK_WORDS : 2 * BLOCK_WORDS;
    for (int i = 0; i < n; i++) begin
      data_rng = xorshift32(data_rng);
      send_beat(data_rng, i == n - 1);
    end
    // Start command offered while the block drains, must not be taken
    ss_tvalid <= 1'b1;
    ss_tdata  <= {28'h0, ntt_buf_pkg::CMD_START, 2'b00};
    do begin
      @(posedge axi_clk);
    end while (!(sm_tvalid && sm_tready && sm_tlast));
    read_status(32'd1);
    write_status(32'd0);
    read_status(32'd1);   // Bit 0 clear keeps the block done
    ss_tvalid <= 1'b0;
    write_status(32'd1);
    read_status(32'd0);
  endtask

  initial begin
    axi_reset_n <= 1'b0;
    ss_tvalid   <= 1'b0;
    ss_tdata    <= '0;
    ss_tlast    <= 1'b0;
    sm_tready   <= 1'b0;
    awvalid     <= 1'b0;
    awaddr      <= '0;
    wvalid      <= 1'b0;
    wdata       <= '0;
    arvalid     <= 1'b0;
    araddr      <= '0;
    rready      <= 1'b0;
    gap_mode    <= 1'b0;
    stall_mode  <= 1'b0;
    cycle_cnt   = 0;
    reg_errors  = 0;
    data_rng    = 32'd42;
    stall_rng   = 32'd42;
    repeat (4) @(posedge axi_clk);
    axi_reset_n <= 1'b1;
    @(posedge axi_clk);
    if (sm_tvalid !== 1'b0 || rvalid !== 1'b0) begin
      reg_errors++;
      $display("MISMATCH at %0t: sm_tvalid or rvalid is high after reset", $time);
    end
    read_status(32'd0);
    run_block(1'b1, 1'b0);
    run_block(1'b0, 1'b0);
    gap_mode   <= 1'b1;
    stall_mode <= 1'b1;
    run_block(1'b1, 1'b0);
    run_block(1'b0, 1'b0);
    run_block(1'b0, 1'b1);
    repeat (5) @(posedge axi_clk);
    total_errors = stream_errors + reg_errors + ntt_buf_top_inst.ntt_buf_assert_inst.fail_count;
    $display("Checked %0d beats: %0d stream errors, %0d register errors, %0d assertion failures",
             beats_checked, stream_errors, reg_errors,
             ntt_buf_top_inst.ntt_buf_assert_inst.fail_count);
    if (total_errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== build.f ====
verilog/ntt_buf_pkg.sv
verilog/sram_lane.sv
verilog/xform_ctrl.sv
verilog/stream_loader.sv
verilog/stream_unloader.sv
verilog/ntt_buf_top.sv
dv/ntt_buf_assert.sv
dv/ntt_buf_checker.sv
dv/tb_ntt_buf.sv

// ==== Bender.yml ====
package:
  name: ntt_buf

sources:
  - files:
      - verilog/ntt_buf_pkg.sv
      - verilog/sram_lane.sv
      - verilog/xform_ctrl.sv
      - verilog/stream_loader.sv
      - verilog/stream_unloader.sv
      - verilog/ntt_buf_top.sv
  - target: test
    files:
      - dv/ntt_buf_assert.sv
      - dv/ntt_buf_checker.sv
      - dv/tb_ntt_buf.sv
